/* iwm_pkg.sv */
// IWM shared constants
package iwm_pkg;

    // ==========================================================================
    // Soft switch select, taken from address bits 3:1
    // ==========================================================================
    localparam logic [2:0] SW_PHASE0    = 3'd0;
    localparam logic [2:0] SW_PHASE1    = 3'd1;
    localparam logic [2:0] SW_PHASE2    = 3'd2;
    localparam logic [2:0] SW_PHASE3    = 3'd3;
    localparam logic [2:0] SW_MOTOR     = 3'd4;
    localparam logic [2:0] SW_DRIVE_SEL = 3'd5;
    localparam logic [2:0] SW_Q6        = 3'd6;
    localparam logic [2:0] SW_Q7        = 3'd7;

    // Writable part of the mode register
    localparam int MODE_BITS = 5;

    // Bit positions in the DISK35 control byte
    localparam int DISK35_SIZE_BIT = 6;
    localparam int DISK35_SEL_BIT  = 7;

    // ==========================================================================
    // Register read values
    // ==========================================================================
    // Write buffer empty and no underrun
    localparam logic [7:0] HANDSHAKE_IDLE = 8'hC0;
    // Returned on data reads since no read head is present
    localparam logic [7:0] DATA_NONE      = 8'hFF;

    // ==========================================================================
    // 3.5-inch status sense indices, {SEL, phase2, phase1, phase0}
    // ==========================================================================
    localparam logic [3:0] SENSE_DISK_IN   = 4'd2;
    localparam logic [3:0] SENSE_WP        = 4'd3;
    localparam logic [3:0] SENSE_MOTOR     = 4'd4;
    localparam logic [3:0] SENSE_TWO_SIDED = 4'd9;

endpackage

/* iwm_soft_switches.sv */
// IWM soft switches and mode register
`timescale 1ns/100ps

module iwm_soft_switches (
    input  logic       CLK_14M,
    input  logic       RESET,
    input  logic       DEVICE_SELECT,
    input  logic       WR_CYCLE,
    input  logic       PH2,
    input  logic [3:0] A,
    input  logic [7:0] D_IN,
    output logic [3:0] phases,
    output logic       drive_on,
    output logic       drive_sel,
    output logic       q6,
    output logic       q7,
    output logic       imm_motor,
    output logic [7:0] imm_mode,
    output logic [2:0] imm_sense_reg
);
    import iwm_pkg::*;

    // Set once the access is handled and cleared when DEVICE_SELECT drops
    logic                 access_done;
    logic                 access_edge;
    logic                 cpu_wr;
    logic                 phase_access;
    logic                 imm_q6;
    logic                 imm_q7;
    logic [2:0]           imm_phases;
    logic                 mode_write;
    logic [MODE_BITS-1:0] mode_reg;
    logic [MODE_BITS-1:0] mode_sel;
    logic [2:0]           sense_reg;

    // ==========================================================================
    // Access qualification
    // ==========================================================================
    // First PH2 clock of each access
    assign access_edge  = DEVICE_SELECT && PH2 && !access_done;
    // WR_CYCLE low marks a write
    assign cpu_wr       = DEVICE_SELECT && !WR_CYCLE;
    assign phase_access = (A[3:1] <= SW_PHASE3);

    // ==========================================================================
    // Immediate values that already show what this access stores
    // ==========================================================================
    assign imm_q6    = (DEVICE_SELECT && A[3:1] == SW_Q6) ? A[0] : q6;
    assign imm_q7    = (DEVICE_SELECT && A[3:1] == SW_Q7) ? A[0] : q7;
    assign imm_motor = (DEVICE_SELECT && A[3:1] == SW_MOTOR) ? A[0] : drive_on;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            imm_phases[i] = (DEVICE_SELECT && A[3:1] == SW_PHASE0 + 3'(i)) ? A[0] : phases[i];
        end
    end

    // Mode load needs motor off, Q6 and Q7 set, odd address
    assign mode_write = cpu_wr && !drive_on && imm_q6 && imm_q7 && A[0];
    assign mode_sel   = mode_write ? D_IN[MODE_BITS-1:0] : mode_reg;
    // Upper mode bits always read back as zero
    assign imm_mode   = {{(8 - MODE_BITS){1'b0}}, mode_sel};

    // Phase access shows its new index right away
    assign imm_sense_reg = (DEVICE_SELECT && phase_access) ? imm_phases[2:0] : sense_reg;

    // ==========================================================================
    // Switch registers
    // ==========================================================================
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            access_done <= 1'b0;
            phases      <= 4'b0000;
            drive_on    <= 1'b0;
            drive_sel   <= 1'b0;
            q6          <= 1'b0;
            q7          <= 1'b0;
            mode_reg    <= '0;
            sense_reg   <= 3'b000;
        end else begin
            // Re-arm for the next access
            if (!DEVICE_SELECT) begin
                access_done <= 1'b0;
            end
            if (access_edge) begin
                access_done <= 1'b1;
                // A[0] is the new switch value
                case (A[3:1])
                    SW_PHASE0:    phases[0] <= A[0];
                    SW_PHASE1:    phases[1] <= A[0];
                    SW_PHASE2:    phases[2] <= A[0];
                    SW_PHASE3:    phases[3] <= A[0];
                    SW_MOTOR:     drive_on  <= A[0];
                    SW_DRIVE_SEL: drive_sel <= A[0];
                    SW_Q6:        q6        <= A[0];
                    default:      q7        <= A[0];
                endcase
                // Any phase access latches the sense index whether it sets or clears
                if (phase_access) begin
                    sense_reg <= imm_phases[2:0];
                end
                if (mode_write) begin
                    mode_reg <= D_IN[MODE_BITS-1:0];
                end
            end
        end
    end

endmodule

/* spindle_motor.sv */
// 5.25-inch spindle inertia
`timescale 1ns/100ps

module spindle_motor #(
    parameter int SPINUP_CYCLES   = 4200000,
    parameter int SPINDOWN_CYCLES = 14000000
) (
    input  logic CLK_14M,
    input  logic RESET,
    input  logic drive_on,
    input  logic is_35,
    output logic spinning
);

    // Counter must hold both the spin-up target and the parked value
    localparam int CNT_MAX = (SPINDOWN_CYCLES > SPINUP_CYCLES) ? SPINDOWN_CYCLES : SPINUP_CYCLES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    logic [CNT_W-1:0] count;
    logic             spinup_done;
    logic             spin_q;

    // ==========================================================================
    // Spin-up counts up, spin-down counts back from the parked value
    // ==========================================================================
    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            count       <= '0;
            spinup_done <= 1'b0;
            spin_q      <= 1'b0;
        end else if (is_35) begin
            // 3.5-inch drives keep their own motor, no inertia here
            count       <= '0;
            spinup_done <= 1'b0;
            spin_q      <= 1'b0;
        end else if (drive_on) begin
            if (!spinup_done) begin
                if (count >= CNT_W'(SPINUP_CYCLES)) begin
                    spin_q      <= 1'b1;
                    spinup_done <= 1'b1;
                    count       <= CNT_W'(SPINDOWN_CYCLES);
                end else begin
                    count <= count + 1'b1;
                end
            end else begin
                // Up to speed, hold the counter parked
                spin_q <= 1'b1;
                count  <= CNT_W'(SPINDOWN_CYCLES);
            end
        end else begin
            // Motor off, coast down
            spinup_done <= 1'b0;
            if (count != '0) begin
                count <= count - 1'b1;
            end else begin
                spin_q <= 1'b0;
            end
        end
    end

    // Low in the same cycle the size bit selects 3.5-inch
    assign spinning = spin_q && !is_35;

endmodule

/* drive_sense.sv */
// Drive status sense
`timescale 1ns/100ps

module drive_sense (
    input  logic       drive_on,
    input  logic       drive_sel,
    input  logic       is_35,
    input  logic       diskreg_sel,
    input  logic [2:0] imm_sense_reg,
    input  logic       disk_ready,
    input  logic       write_protect,
    output logic       sense
);
    import iwm_pkg::*;

    // Full 3.5-inch status index
    logic [3:0] sense_idx;

    assign sense_idx = {diskreg_sel, imm_sense_reg};

    // ==========================================================================
    // Sense selection
    // ==========================================================================
    // Drive 1 is internal, drive 2 is an empty external unit
    always_comb begin
        // No drive enabled, line floats high
        sense = 1'b1;
        if (drive_on) begin
            if (!is_35) begin
                // 5.25-inch drive 1 reports write protect directly
                sense = drive_sel ? 1'b1 : write_protect;
            end else begin
                case (sense_idx)
                    SENSE_DISK_IN: begin
                        // Low when a disk is inserted
                        sense = drive_sel ? 1'b1 : !disk_ready;
                    end
                    SENSE_WP: begin
                        // Low when write protected
                        sense = drive_sel ? 1'b1 : !write_protect;
                    end
                    SENSE_MOTOR: begin
                        sense = 1'b0;
                    end
                    SENSE_TWO_SIDED: begin
                        // Both drives report double sided
                        sense = 1'b0;
                    end
                    default: begin
                        sense = 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

/* iwm_register_read.sv */
// IWM register read mux
`timescale 1ns/100ps

module iwm_register_read (
    input  logic       q6,
    input  logic       q7,
    input  logic       imm_motor,
    input  logic [7:0] imm_mode,
    input  logic       sense,
    output logic [7:0] data_out
);
    import iwm_pkg::*;

    logic [7:0] status;

    // ==========================================================================
    // Status byte
    // ==========================================================================
    // Sense on top, bit 6 reserved, motor state, then mode
    assign status = {sense, 1'b0, imm_motor, imm_mode[MODE_BITS-1:0]};

    // ==========================================================================
    // Register select by Q7 and Q6
    // ==========================================================================
    always_comb begin
        case ({q7, q6})
            2'b01: begin
                data_out = status;
            end
            2'b10: begin
                // Write handshake
                data_out = HANDSHAKE_IDLE;
            end
            2'b00: begin
                // Data register, nothing shifted in
                data_out = DATA_NONE;
            end
            default: begin
                // Write state, reads mirror status
                data_out = status;
            end
        endcase
    end

endmodule

/* iwm_woz.sv */
// IWM floppy controller top
`timescale 1ns/100ps

module iwm_woz #(
    parameter int SPINUP_CYCLES   = 4200000,
    parameter int SPINDOWN_CYCLES = 14000000
) (
    input  logic        CLK_14M,
    input  logic        RESET,
    input  logic        PH2,
    input  logic        DEVICE_SELECT,
    // High for read, low for write
    input  logic        WR_CYCLE,
    input  logic [15:0] A,
    input  logic [7:0]  D_IN,
    input  logic [3:0]  DISK_READY,
    input  logic [7:0]  DISK35,
    input  logic        WRITE_PROTECT,
    output logic [7:0]  D_OUT,
    output logic        FLOPPY_MOTOR_ON
);
    import iwm_pkg::*;

    logic       drive_on;
    logic       drive_sel;
    logic       q6;
    logic       q7;
    logic       imm_motor;
    logic [7:0] imm_mode;
    logic [2:0] imm_sense_reg;
    logic       is_35;
    logic       diskreg_sel;
    logic       sense;

    // ==========================================================================
    // DISK35 control byte fields
    // ==========================================================================
    assign is_35       = DISK35[DISK35_SIZE_BIT];
    assign diskreg_sel = DISK35[DISK35_SEL_BIT];

    // Switch state decoded from the low address nibble
    iwm_soft_switches u_switches (
        .CLK_14M(CLK_14M), .RESET(RESET), .DEVICE_SELECT(DEVICE_SELECT),
        .WR_CYCLE(WR_CYCLE), .PH2(PH2), .A(A[3:0]), .D_IN(D_IN),
        .phases(), .drive_on(drive_on), .drive_sel(drive_sel),
        .q6(q6), .q7(q7), .imm_motor(imm_motor), .imm_mode(imm_mode),
        .imm_sense_reg(imm_sense_reg)
    );

    spindle_motor #(
        .SPINUP_CYCLES(SPINUP_CYCLES), .SPINDOWN_CYCLES(SPINDOWN_CYCLES)
    ) u_spindle (
        .CLK_14M(CLK_14M), .RESET(RESET), .drive_on(drive_on),
        .is_35(is_35), .spinning(FLOPPY_MOTOR_ON)
    );

    // Internal 3.5-inch drive sits on DISK_READY bit 2
    drive_sense u_sense (
        .drive_on(drive_on), .drive_sel(drive_sel), .is_35(is_35),
        .diskreg_sel(diskreg_sel), .imm_sense_reg(imm_sense_reg),
        .disk_ready(DISK_READY[2]), .write_protect(WRITE_PROTECT), .sense(sense)
    );

    iwm_register_read u_read (
        .q6(q6), .q7(q7), .imm_motor(imm_motor), .imm_mode(imm_mode),
        .sense(sense), .data_out(D_OUT)
    );

endmodule

/* iwm_props.sv */
// Switch and spindle assertions
`timescale 1ns/100ps

module iwm_props (
    input logic                          CLK_14M,
    input logic                          RESET,
    input logic                          access_edge,
    input logic                          mode_write,
    input logic [iwm_pkg::MODE_BITS-1:0] mode_reg,
    input logic [7:0]                    switches,
    input logic                          is_35,
    input logic                          spinning
);
    // Count of failed assertions
    int failures = 0;

    // Mode register moves only on a qualifying write at an access edge
    a_mode_write: assert property (@(posedge CLK_14M) disable iff (RESET)
        $changed(mode_reg) |-> $past(access_edge && mode_write))
    else begin
        failures++;
        $error("mode register changed without a qualifying write");
    end

    // Switches follow the access edge by one clock
    a_switch_edge: assert property (@(posedge CLK_14M) disable iff (RESET)
        $changed(switches) |-> $past(access_edge))
    else begin
        failures++;
        $error("soft switch changed without an access edge");
    end

    // Spindle register cleared one clock into 3.5-inch mode
    a_spin_35: assert property (@(posedge CLK_14M) disable iff (RESET)
        is_35 |=> !spinning)
    else begin
        failures++;
        $error("spindle register still high in 3.5-inch mode");
    end

endmodule

// Each side ties off the ports it does not have
bind iwm_soft_switches iwm_props u_props (
    .CLK_14M(CLK_14M), .RESET(RESET), .access_edge(access_edge),
    .mode_write(mode_write), .mode_reg(mode_reg),
    .switches({phases, drive_on, drive_sel, q6, q7}),
    .is_35(1'b0), .spinning(1'b0)
);

bind spindle_motor iwm_props u_props (
    .CLK_14M(CLK_14M), .RESET(RESET), .access_edge(1'b0), .mode_write(1'b0),
    .mode_reg('0), .switches(8'h00), .is_35(is_35), .spinning(spin_q)
);

/* tb_iwm.sv */
// IWM front end testbench
`timescale 1ns/100ps

module tb_iwm;
    localparam int SPINUP   = 16;
    localparam int SPINDOWN = 40;
    localparam int N_RAND   = 300;
    // Random run plus the directed accesses that follow it
    localparam int N_ACCESS = N_RAND + 40;
    localparam int LIMIT    = 2 * N_ACCESS * 3 + 4 * (SPINUP + SPINDOWN);

    logic        CLK_14M;
    logic        RESET;
    logic        PH2;
    logic        DEVICE_SELECT;
    logic        WR_CYCLE;
    logic [15:0] A;
    logic [7:0]  D_IN;
    logic [3:0]  DISK_READY;
    logic [7:0]  DISK35;
    logic        WRITE_PROTECT;
    logic [7:0]  D_OUT;
    logic        FLOPPY_MOTOR_ON;

    // Reference state of the controller
    logic [3:0]  m_phases;
    logic        m_motor;
    logic        m_dsel;
    logic        m_q6;
    logic        m_q7;
    logic [4:0]  m_mode;
    logic [2:0]  m_sidx;

    logic [31:0] seed = 32'h68b;
    logic [7:0]  last_dout;
    int          errors = 0;
    int          checks = 0;
    int          cycle = 0;
    int          edge_cycle = 0;

    iwm_woz #(.SPINUP_CYCLES(SPINUP), .SPINDOWN_CYCLES(SPINDOWN)) DUT (
        .CLK_14M(CLK_14M), .RESET(RESET), .PH2(PH2), .DEVICE_SELECT(DEVICE_SELECT),
        .WR_CYCLE(WR_CYCLE), .A(A), .D_IN(D_IN), .DISK_READY(DISK_READY),
        .DISK35(DISK35), .WRITE_PROTECT(WRITE_PROTECT), .D_OUT(D_OUT),
        .FLOPPY_MOTOR_ON(FLOPPY_MOTOR_ON)
    );

    initial begin
        CLK_14M = 1'b0;
        forever #4 CLK_14M = ~CLK_14M;
    end

    always @(posedge CLK_14M) begin
        cycle <= cycle + 1;
    end

    // Watchdog sized from the access count and the spin times
    initial begin : watchdog
        while (cycle < LIMIT) begin
            @(posedge CLK_14M);
        end
        $display("timeout: simulation ran past %0d cycles", LIMIT);
        $display("** FAIL **");
        $finish;
    end

    // ==========================================================================
    // Helpers
    // ==========================================================================
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Predicted read value with registers from the model and immediate fields from addr
    function automatic logic [7:0] expect_read(input logic [3:0] addr);
        logic [3:0] ph;
        logic       motor;
        logic [3:0] idx;
        logic       sense;
        ph = m_phases;
        // Addresses 0 to 7 are phase switches
        if (!addr[3]) begin
            ph[addr[2:1]] = addr[0];
        end
        motor = (addr[3:1] == 3'd4) ? addr[0] : m_motor;
        idx = {DISK35[7], (!addr[3]) ? ph[2:0] : m_sidx};
        if (!m_motor) begin
            sense = 1'b1;
        end else if (!DISK35[6]) begin
            sense = m_dsel | WRITE_PROTECT;
        end else begin
            // Drive 2 is empty, so only drive 1 reports disk and write protect
            case (idx)
                4'd2: sense = m_dsel | !DISK_READY[2];
                4'd3: sense = m_dsel | !WRITE_PROTECT;
                4'd4, 4'd9: sense = 1'b0;
                default: sense = 1'b1;
            endcase
        end
        case ({m_q7, m_q6})
            2'b10: return 8'hC0;
            2'b00: return 8'hFF;
            default: return {sense, 1'b0, motor, m_mode};
        endcase
    endfunction

    // One bus access entered and left just after a falling edge
    task automatic bus_access(input logic [3:0] addr, input logic rd, input logic [7:0] data,
                              input string name);
        logic [7:0] expected;
        logic       wr_q6;
        logic       wr_q7;
        DEVICE_SELECT = 1'b1;
        PH2 = 1'b1;
        WR_CYCLE = rd;
        A = {12'hC0E, addr};
        D_IN = data;
        expected = expect_read(addr);
        wr_q6 = (addr[3:1] == 3'd6) ? addr[0] : m_q6;
        wr_q7 = (addr[3:1] == 3'd7) ? addr[0] : m_q7;
        #2;
        last_dout = D_OUT;
        if (rd) begin
            check_value(name, expected, D_OUT);
        end
        @(negedge CLK_14M);
        edge_cycle = cycle;
        // Mode load judged before the motor switch moves
        if (!rd && !m_motor && wr_q6 && wr_q7 && addr[0]) begin
            m_mode = data[4:0];
        end
        if (!addr[3]) begin
            m_phases[addr[2:1]] = addr[0];
            m_sidx = m_phases[2:0];
        end
        case (addr[3:1])
            3'd4: m_motor = addr[0];
            3'd5: m_dsel = addr[0];
            3'd6: m_q6 = addr[0];
            3'd7: m_q7 = addr[0];
            default: ;
        endcase
        @(negedge CLK_14M);
        DEVICE_SELECT = 1'b0;
        PH2 = 1'b0;
        WR_CYCLE = 1'b1;
        @(negedge CLK_14M);
    endtask

    // Motor output level reached within +/-2 cycles of nominal after the last access edge
    task automatic spin_wait(input logic level, input int nominal, input string name);
        int elapsed;
        checks++;
        elapsed = cycle - edge_cycle;
        while (FLOPPY_MOTOR_ON !== level && elapsed <= nominal + 2) begin
            @(negedge CLK_14M);
            elapsed = cycle - edge_cycle;
        end
        if (elapsed < nominal - 2 || elapsed > nominal + 2) begin
            errors++;
            $display("%s: motor output took %0d cycles, expected %0d +/- 2",
                     name, elapsed, nominal);
        end
    endtask

    // ==========================================================================
    // Stimulus
    // ==========================================================================
    initial begin : stimulus
        logic [31:0] r;
        RESET = 1'b1;
        PH2 = 1'b0;
        DEVICE_SELECT = 1'b0;
        WR_CYCLE = 1'b1;
        A = 16'h0000;
        D_IN = 8'h00;
        DISK_READY = 4'h0;
        DISK35 = 8'h00;
        WRITE_PROTECT = 1'b0;
        m_phases = 4'h0;
        m_motor = 1'b0;
        m_dsel = 1'b0;
        m_q6 = 1'b0;
        m_q7 = 1'b0;
        m_mode = 5'h00;
        m_sidx = 3'h0;
        repeat (8) @(posedge CLK_14M);
        @(negedge CLK_14M);
        RESET = 1'b0;
        @(negedge CLK_14M);

        // Random switches, mode writes and sense inputs with mostly reads
        for (int i = 0; i < N_RAND; i++) begin
            r = next_rand();
            DISK35 = {r[31:30], 6'b000000};
            DISK_READY = r[29:26];
            WRITE_PROTECT = r[25];
            // Upper generator bits, the low ones repeat every few steps
            bus_access(r[21:18], r[17] | r[16], r[15:8], "random");
        end

        // Motor bit shows in the same access that turns the motor on
        bus_access(4'h8, 1'b1, 8'h00, "motor_off");
        bus_access(4'hE, 1'b1, 8'h00, "q7_off");
        bus_access(4'hD, 1'b1, 8'h00, "q6_on");
        bus_access(4'h9, 1'b1, 8'h00, "motor_on_read");
        check_value("motor_bit", 8'h01, {7'b0000000, last_dout[5]});

        // Q7 set by the loading write itself
        bus_access(4'h8, 1'b0, 8'h00, "motor_off_wr");
        bus_access(4'hF, 1'b0, 8'hF5, "mode_write");
        bus_access(4'hE, 1'b1, 8'h00, "q7_off_read");
        check_value("mode_load", 8'h15, {3'b000, last_dout[4:0]});
        bus_access(4'h9, 1'b0, 8'h00, "motor_on_wr");
        bus_access(4'hF, 1'b0, 8'h0A, "mode_blocked");
        bus_access(4'hE, 1'b1, 8'h00, "mode_kept");
        check_value("mode_kept", 8'h15, {3'b000, last_dout[4:0]});

        // Every Q7/Q6 pair
        for (int s = 0; s < 4; s++) begin
            bus_access({3'b111, s[1]}, 1'b0, 8'h00, "sel_q7");
            bus_access({3'b110, s[0]}, 1'b1, 8'h00, "sel_q6");
            bus_access(4'h1, 1'b1, 8'h00, "sel_read");
        end

        // 5.25-inch spindle with the counter cleared first by the size bit
        DISK35 = 8'h40;
        bus_access(4'h8, 1'b0, 8'h00, "spin_off");
        DISK35 = 8'h00;
        bus_access(4'h9, 1'b0, 8'h00, "spin_on");
        spin_wait(1'b1, SPINUP + 1, "spin_up");
        bus_access(4'h8, 1'b0, 8'h00, "spin_down_start");
        spin_wait(1'b0, SPINDOWN + 1, "spin_down");

        // 3.5-inch drive gives no spindle output at all
        DISK35 = 8'h40;
        bus_access(4'h9, 1'b0, 8'h00, "spin35_on");
        repeat (2 * SPINUP) begin
            @(negedge CLK_14M);
            check_value("spin35_low", 8'h00, {7'b0000000, FLOPPY_MOTOR_ON});
        end
        bus_access(4'h8, 1'b0, 8'h00, "spin35_off");

        errors = errors + DUT.u_switches.u_props.failures + DUT.u_spindle.u_props.failures;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Compile and run the IWM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_iwm -f flist.f -o sim_iwm
./obj_dir/sim_iwm | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "Simulation did not pass"
exit 1

/* flist.f */
iwm_pkg.sv
iwm_soft_switches.sv
spindle_motor.sv
drive_sense.sv
iwm_register_read.sv
iwm_woz.sv
iwm_props.sv
tb_iwm.sv
